// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Widths.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;
    typedef logic [63:0] bus64_t;
    typedef logic [31:0] mem_addr_t;     // RAM decodes bits 7 to 0 only.
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [2:0]  credit_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Sizes and fixed values.
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int        IN_DEPTH     = 4;
    localparam int        OUT_CREDITS  = 4;
    localparam int        RAM_WORDS    = 64;
    localparam int        CSR_COUNT    = 8;     // General CSRs at 0 to 7.
    localparam csr_addr_t CSR_TID_ADDR = 14'h0040;
    localparam word_t     TID_VALUE    = 32'h0000_0035;

    typedef enum logic [3:0] {
        OP_ALU,
        OP_LD_B,
        OP_LD_BU,
        OP_LD_H,
        OP_LD_HU,
        OP_LD_W,
        OP_ST_B,
        OP_ST_W,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_RDCNTID,
        OP_RDCNTVLW,
        OP_RDCNTVHW
    } mem_op_t;

    typedef enum logic {
        ACC_IDLE,
        ACC_WAIT_RAM
    } access_state_t;

    typedef struct packed {
        mem_op_t   op;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        word_t     reg_write_data;  // ALU result or store data.
        mem_addr_t mem_addr;
        csr_addr_t csr_addr;
        word_t     csr_write_data;
        word_t     csr_mask;
    } ex_mem_t;

    typedef struct packed {
        logic      write_en;
        reg_addr_t write_addr;
        word_t     write_data;
    } mem_wb_t;

    typedef struct packed {
        logic      write_en;
        csr_addr_t write_addr;
        word_t     write_data;
    } csr_write_t;

endpackage

// ==== rtl/mem_issue_queue.sv ====
`timescale 1ns/10ps

module mem_issue_queue (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  mem_pkg::ex_mem_t in_op,
    input  logic             issue_pop,
    output logic             in_credit,
    output logic             issue_valid,
    output mem_pkg::ex_mem_t issue_op
);

    mem_pkg::ex_mem_t                     fifo [mem_pkg::IN_DEPTH];
    logic [$clog2(mem_pkg::IN_DEPTH)-1:0] wr_ptr;
    logic [$clog2(mem_pkg::IN_DEPTH)-1:0] rd_ptr;
    mem_pkg::credit_t                     count;

    assign issue_valid = (count != '0);
    assign issue_op    = fifo[rd_ptr];

    // Entry storage.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo[wr_ptr] <= in_op;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Pointers and credits.
    // ~~~~~~~~~~~~~~~~~~~~
    // Depth is a power of two so the pointers wrap on their own.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count + mem_pkg::credit_t'(in_valid)
                               - mem_pkg::credit_t'(issue_pop);
            in_credit <= issue_pop;   // One credit back per pop.
        end
    end

endmodule

// ==== rtl/mem_access.sv ====
`timescale 1ns/10ps

module mem_access (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  mem_pkg::ex_mem_t    issue_op,
    input  logic                out_has_credit,
    input  mem_pkg::word_t      ram_rdata,
    input  mem_pkg::word_t      csr_read_data,
    input  mem_pkg::csr_write_t csr_commit,
    input  mem_pkg::bus64_t     cnt,
    output logic                issue_pop,
    output logic                ram_req,
    output mem_pkg::mem_addr_t  ram_addr,
    output logic [3:0]          ram_we,
    output mem_pkg::word_t      ram_wdata,
    output mem_pkg::csr_addr_t  csr_read_addr,
    output logic                res_valid,
    output mem_pkg::mem_wb_t    res,
    output mem_pkg::csr_write_t res_csr
);

    mem_pkg::access_state_t state;
    mem_pkg::ex_mem_t       cur_op;     // Load or store waiting on the RAM.
    logic                   head_is_mem;
    logic                   csr_fwd;
    mem_pkg::word_t         csr_old;
    mem_pkg::mem_wb_t       imm_res;
    mem_pkg::csr_write_t    imm_csr;
    mem_pkg::mem_wb_t       ld_res;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;

    assign head_is_mem = issue_op.op inside {mem_pkg::OP_LD_B, mem_pkg::OP_LD_BU,
                                             mem_pkg::OP_LD_H, mem_pkg::OP_LD_HU,
                                             mem_pkg::OP_LD_W, mem_pkg::OP_ST_B,
                                             mem_pkg::OP_ST_W};

    // No pop while a result is leaving, so the credit count is current.
    assign issue_pop = (state == mem_pkg::ACC_IDLE) && !res_valid && issue_valid
                       && out_has_credit;

    // ~~~~~~~~~~~~~~~~~~~~
    // RAM request.
    // ~~~~~~~~~~~~~~~~~~~~
    assign ram_req  = issue_pop && head_is_mem;
    assign ram_addr = issue_op.mem_addr;

    always_comb begin
        ram_we    = 4'b0000;
        ram_wdata = issue_op.reg_write_data;
        if (ram_req && issue_op.op == mem_pkg::OP_ST_B) begin
            ram_we    = 4'b0001 << issue_op.mem_addr[1:0];
            ram_wdata = {4{issue_op.reg_write_data[7:0]}};  // Byte on every lane.
        end else if (ram_req && issue_op.op == mem_pkg::OP_ST_W) begin
            ram_we = 4'b1111;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // CSR read with forwarding.
    // ~~~~~~~~~~~~~~~~~~~~
    assign csr_read_addr = (issue_op.op == mem_pkg::OP_RDCNTID) ? mem_pkg::CSR_TID_ADDR
                                                                : issue_op.csr_addr;
    // Only the general registers take writes, so only they forward.
    assign csr_fwd = csr_commit.write_en && (csr_commit.write_addr == csr_read_addr)
                     && (csr_commit.write_addr < mem_pkg::CSR_COUNT);
    assign csr_old = csr_fwd ? csr_commit.write_data : csr_read_data;

    always_comb begin
        imm_res.write_en   = issue_op.reg_write_en;
        imm_res.write_addr = issue_op.reg_write_addr;
        imm_res.write_data = issue_op.reg_write_data;   // ALU pass-through.
        imm_csr.write_en   = 1'b0;
        imm_csr.write_addr = issue_op.csr_addr;
        imm_csr.write_data = issue_op.csr_write_data;
        case (issue_op.op)
            mem_pkg::OP_CSRRD, mem_pkg::OP_RDCNTID: begin
                imm_res.write_data = csr_old;
            end
            mem_pkg::OP_CSRWR: begin
                imm_res.write_data = csr_old;
                imm_csr.write_en   = 1'b1;
            end
            mem_pkg::OP_CSRXCHG: begin
                imm_res.write_data = csr_old;
                imm_csr.write_en   = 1'b1;
                imm_csr.write_data = (csr_old & ~issue_op.csr_mask)
                                   | (issue_op.csr_write_data & issue_op.csr_mask);
            end
            mem_pkg::OP_RDCNTVLW: imm_res.write_data = cnt[31:0];
            mem_pkg::OP_RDCNTVHW: imm_res.write_data = cnt[63:32];
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Load extraction.
    // ~~~~~~~~~~~~~~~~~~~~
    assign ld_byte = ram_rdata[{cur_op.mem_addr[1:0], 3'b000} +: 8];
    assign ld_half = cur_op.mem_addr[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        ld_res.write_en   = cur_op.reg_write_en;
        ld_res.write_addr = cur_op.reg_write_addr;
        case (cur_op.op)
            mem_pkg::OP_LD_B:  ld_res.write_data = {{24{ld_byte[7]}}, ld_byte};
            mem_pkg::OP_LD_BU: ld_res.write_data = {24'b0, ld_byte};
            mem_pkg::OP_LD_H: begin
                ld_res.write_data = cur_op.mem_addr[0] ? '0 : {{16{ld_half[15]}}, ld_half};
            end
            mem_pkg::OP_LD_HU: begin
                ld_res.write_data = cur_op.mem_addr[0] ? '0 : {16'b0, ld_half};
            end
            mem_pkg::OP_LD_W:  ld_res.write_data = ram_rdata;
            default: begin
                ld_res.write_en   = 1'b0;   // Stores write no register.
                ld_res.write_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mem_pkg::ACC_IDLE;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                mem_pkg::ACC_IDLE: begin
                    if (issue_pop && head_is_mem) begin
                        state <= mem_pkg::ACC_WAIT_RAM;
                    end else if (issue_pop) begin
                        res_valid <= 1'b1;
                    end
                end
                mem_pkg::ACC_WAIT_RAM: begin
                    state     <= mem_pkg::ACC_IDLE;
                    res_valid <= 1'b1;
                end
                default: state <= mem_pkg::ACC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_pop) begin
            cur_op <= issue_op;
        end
        if (issue_pop && !head_is_mem) begin
            res     <= imm_res;
            res_csr <= imm_csr;
        end else if (state == mem_pkg::ACC_WAIT_RAM) begin
            res                <= ld_res;
            res_csr.write_en   <= 1'b0;
            res_csr.write_addr <= cur_op.csr_addr;
            res_csr.write_data <= cur_op.csr_write_data;
        end
    end

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/10ps

module data_ram (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ram_req,
    input  mem_pkg::mem_addr_t ram_addr,
    input  logic [3:0]         ram_we,
    input  mem_pkg::word_t     ram_wdata,
    output mem_pkg::word_t     ram_rdata
);

    mem_pkg::word_t                        mem [mem_pkg::RAM_WORDS];
    logic [$clog2(mem_pkg::RAM_WORDS)-1:0] word_idx;

    assign word_idx = ram_addr[7:2];   // Word index, byte offset dropped.

    // ~~~~~~~~~~~~~~~~~~~~
    // Byte-lane write, registered read.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
            ram_rdata <= '0;
        end else if (ram_req) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_we[b]) begin
                    mem[word_idx][8*b +: 8] <= ram_wdata[8*b +: 8];
                end
            end
            ram_rdata <= mem[word_idx];   // Old data on a store.
        end
    end

endmodule

// ==== rtl/csr_file.sv ====
`timescale 1ns/10ps

module csr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::csr_addr_t  csr_read_addr,
    input  mem_pkg::csr_write_t csr_commit,
    output mem_pkg::word_t      csr_read_data
);

    mem_pkg::word_t                        regs [mem_pkg::CSR_COUNT];
    logic [$clog2(mem_pkg::CSR_COUNT)-1:0] wr_idx;
    logic [$clog2(mem_pkg::CSR_COUNT)-1:0] rd_idx;
    logic                                  wr_hit;

    assign wr_idx = csr_commit.write_addr[$clog2(mem_pkg::CSR_COUNT)-1:0];
    assign rd_idx = csr_read_addr[$clog2(mem_pkg::CSR_COUNT)-1:0];
    // Writes to the thread ID or unmapped addresses are dropped.
    assign wr_hit = csr_commit.write_en && (csr_commit.write_addr < mem_pkg::CSR_COUNT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::CSR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wr_idx] <= csr_commit.write_data;
        end
    end

    always_comb begin
        if (csr_read_addr < mem_pkg::CSR_COUNT) begin
            csr_read_data = regs[rd_idx];
        end else if (csr_read_addr == mem_pkg::CSR_TID_ADDR) begin
            csr_read_data = mem_pkg::TID_VALUE;
        end else begin
            csr_read_data = '0;
        end
    end

endmodule

// ==== rtl/mem_writeback.sv ====
`timescale 1ns/10ps

module mem_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                res_valid,
    input  mem_pkg::mem_wb_t    res,
    input  mem_pkg::csr_write_t res_csr,
    input  logic                out_credit,
    output logic                out_has_credit,
    output logic                out_valid,
    output mem_pkg::mem_wb_t    out_res,
    output mem_pkg::csr_write_t csr_commit
);

    mem_pkg::credit_t   out_cnt;
    logic               commit_en;
    mem_pkg::csr_addr_t commit_addr;
    mem_pkg::word_t     commit_data;

    assign out_has_credit = (out_cnt != '0);

    assign csr_commit = '{write_en:   commit_en,
                          write_addr: commit_addr,
                          write_data: commit_data};

    // ~~~~~~~~~~~~~~~~~~~~
    // Valids and output credits.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            commit_en <= 1'b0;
            out_cnt   <= mem_pkg::credit_t'(mem_pkg::OUT_CREDITS);
        end else begin
            out_valid <= res_valid;
            commit_en <= res_valid && res_csr.write_en;
            out_cnt   <= out_cnt + mem_pkg::credit_t'(out_credit)
                                 - mem_pkg::credit_t'(res_valid);   // Spent per result.
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            out_res     <= res;
            commit_addr <= res_csr.write_addr;
            commit_data <= res_csr.write_data;
        end
    end

endmodule

// ==== rtl/mem_stage_top.sv ====
`timescale 1ns/10ps

module mem_stage_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  mem_pkg::ex_mem_t in_op,
    input  mem_pkg::bus64_t  cnt,
    input  logic             out_credit,
    output logic             in_credit,
    output logic             out_valid,
    output mem_pkg::mem_wb_t out_res
);

    logic                issue_valid;
    mem_pkg::ex_mem_t    issue_op;
    logic                issue_pop;
    logic                out_has_credit;
    logic                ram_req;
    mem_pkg::mem_addr_t  ram_addr;
    logic [3:0]          ram_we;
    mem_pkg::word_t      ram_wdata;
    mem_pkg::word_t      ram_rdata;
    mem_pkg::csr_addr_t  csr_read_addr;
    mem_pkg::word_t      csr_read_data;
    mem_pkg::csr_write_t csr_commit;
    logic                res_valid;
    mem_pkg::mem_wb_t    res;
    mem_pkg::csr_write_t res_csr;

    mem_issue_queue u_issue_queue (.clk, .rst_n, .in_valid, .in_op, .issue_pop,
                                   .in_credit, .issue_valid, .issue_op);

    mem_access u_access (.clk, .rst_n, .issue_valid, .issue_op, .out_has_credit,
                         .ram_rdata, .csr_read_data, .csr_commit, .cnt, .issue_pop,
                         .ram_req, .ram_addr, .ram_we, .ram_wdata, .csr_read_addr,
                         .res_valid, .res, .res_csr);

    data_ram u_data_ram (.clk, .rst_n, .ram_req, .ram_addr, .ram_we, .ram_wdata,
                         .ram_rdata);

    csr_file u_csr_file (.clk, .rst_n, .csr_read_addr, .csr_commit, .csr_read_data);

    mem_writeback u_writeback (.clk, .rst_n, .res_valid, .res, .res_csr, .out_credit,
                               .out_has_credit, .out_valid, .out_res, .csr_commit);

endmodule

// ==== testbench/mem_stage_chk.sv ====
`timescale 1ns/10ps

module mem_stage_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             in_valid,
    input logic             in_credit,
    input logic             issue_pop,
    input logic             ram_req,
    input logic             res_valid,
    input logic             out_valid,
    input logic             commit_en,
    input mem_pkg::credit_t out_cnt,
    input mem_pkg::credit_t queue_count
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Credit rules.
    // ~~~~~~~~~~~~~~~~~~~~
    out_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= mem_pkg::OUT_CREDITS)
        else $error("output credit count above its reset value");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (queue_count < mem_pkg::IN_DEPTH))
        else $error("operation pushed into a full issue queue");

    // ~~~~~~~~~~~~~~~~~~~~
    // Handshake timing.
    // ~~~~~~~~~~~~~~~~~~~~
    out_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(res_valid))
        else $error("out_valid does not follow res_valid by one cycle");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(in_credit || issue_pop || ram_req || res_valid || out_valid || commit_en))
        else $error("control output high during reset");

endmodule

bind mem_stage_top mem_stage_chk u_chk (
    .clk,
    .rst_n,
    .in_valid,
    .in_credit,
    .issue_pop,
    .ram_req,
    .res_valid,
    .out_valid,
    .commit_en   (csr_commit.write_en),
    .out_cnt     (u_writeback.out_cnt),
    .queue_count (u_issue_queue.count)
);

// ==== testbench/mem_stage_tb.sv ====
`timescale 1ns/10ps

module mem_stage_tb;

    localparam string STIM_FILE  = "testbench/mem_stim.txt";
    localparam int    WAIT_LIMIT = 500;

    typedef enum {WAIT_IN_CREDIT, WAIT_DRAIN, WAIT_OUT_RETURN, WAIT_IN_RETURN} wait_kind_t;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    mem_pkg::ex_mem_t in_op;
    mem_pkg::bus64_t  cnt;
    logic             out_credit;
    logic             in_credit;
    logic             out_valid;
    mem_pkg::mem_wb_t out_res;

    mem_pkg::word_t   ref_mem [mem_pkg::RAM_WORDS];
    mem_pkg::word_t   ref_csr [mem_pkg::CSR_COUNT];
    mem_pkg::mem_wb_t exp_q [$];
    bit               full_q [$];   // Low for stores, only write_en is compared.
    int               sent;
    int               credits_back;
    int               rx_count;
    int               returned;
    int               mismatch_errors;
    int               timeout_errors;
    int               other_errors;
    bit               timed_out;
    logic [15:0]      lfsr;

    mem_stage_top DUT (.clk, .rst_n, .in_valid, .in_op, .cnt, .out_credit, .in_credit,
                       .out_valid, .out_res);

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic mem_pkg::word_t csr_value(input mem_pkg::csr_addr_t addr);
        if (addr < mem_pkg::CSR_COUNT) begin
            return ref_csr[addr[2:0]];
        end
        return (addr == mem_pkg::CSR_TID_ADDR) ? mem_pkg::TID_VALUE : '0;
    endfunction

    task automatic model_op(input mem_pkg::ex_mem_t op, input mem_pkg::bus64_t c,
                            output mem_pkg::mem_wb_t r, output bit full);
        logic [5:0]     idx;
        logic [7:0]     b;
        logic [15:0]    h;
        mem_pkg::word_t old;
        mem_pkg::word_t merged;
        idx    = op.mem_addr[7:2];
        b      = 8'(ref_mem[idx] >> (8 * op.mem_addr[1:0]));
        h      = op.mem_addr[1] ? ref_mem[idx][31:16] : ref_mem[idx][15:0];
        old    = csr_value(op.op == mem_pkg::OP_RDCNTID ? mem_pkg::CSR_TID_ADDR : op.csr_addr);
        merged = (old & ~op.csr_mask) | (op.csr_write_data & op.csr_mask);
        r      = '{write_en: op.reg_write_en, write_addr: op.reg_write_addr,
                   write_data: op.reg_write_data};
        full   = 1'b1;
        case (op.op)
            mem_pkg::OP_LD_B:  r.write_data = {{24{b[7]}}, b};
            mem_pkg::OP_LD_BU: r.write_data = {24'h0, b};
            mem_pkg::OP_LD_H:  r.write_data = op.mem_addr[0] ? '0 : {{16{h[15]}}, h};
            mem_pkg::OP_LD_HU: r.write_data = op.mem_addr[0] ? '0 : {16'h0, h};
            mem_pkg::OP_LD_W:  r.write_data = ref_mem[idx];
            mem_pkg::OP_ST_B, mem_pkg::OP_ST_W: begin
                if (op.op == mem_pkg::OP_ST_W) begin
                    ref_mem[idx] = op.reg_write_data;
                end else begin
                    ref_mem[idx][8*op.mem_addr[1:0] +: 8] = op.reg_write_data[7:0];
                end
                r.write_en = 1'b0;
                full       = 1'b0;
            end
            mem_pkg::OP_CSRRD, mem_pkg::OP_RDCNTID: r.write_data = old;
            mem_pkg::OP_CSRWR, mem_pkg::OP_CSRXCHG: begin
                r.write_data = old;
                if (op.csr_addr < mem_pkg::CSR_COUNT) begin   // Thread ID stays fixed.
                    ref_csr[op.csr_addr[2:0]] = (op.op == mem_pkg::OP_CSRWR)
                                                ? op.csr_write_data : merged;
                end
            end
            mem_pkg::OP_RDCNTVLW: r.write_data = c[31:0];
            mem_pkg::OP_RDCNTVHW: r.write_data = c[63:32];
            default: ;
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic bit parse_line(input string s, output mem_pkg::ex_mem_t op,
                                      output mem_pkg::bus64_t c);
        logic [31:0] f [8];
        int          n;
        op = '0;
        c  = '0;
        if (s.len() == 0 || s.getc(0) == "#") begin
            return 1'b0;
        end
        n = $sscanf(s, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5],
                    f[6], f[7], c);
        op = '{op: mem_pkg::mem_op_t'(f[0][3:0]), reg_write_en: f[1][0],
               reg_write_addr: f[2][4:0], reg_write_data: f[3], mem_addr: f[4],
               csr_addr: f[5][13:0], csr_write_data: f[6], csr_mask: f[7]};
        return (n == 9);
    endfunction

    function automatic bit cond_met(input wait_kind_t kind);
        case (kind)
            WAIT_IN_CREDIT:  return (sent - credits_back) < mem_pkg::IN_DEPTH;
            WAIT_DRAIN:      return exp_q.size() == 0;
            WAIT_OUT_RETURN: return rx_count == returned;
            default:         return credits_back == sent;
        endcase
    endfunction

    task automatic next_drive_slot();
        @(posedge clk);
        #0.5;
    endtask

    task automatic wait_for(input wait_kind_t kind, input string what);
        int cycles;
        cycles = 0;
        while (!timed_out && !cond_met(kind) && cycles < WAIT_LIMIT) begin
            next_drive_slot();
            cycles++;
        end
        if (!timed_out && !cond_met(kind)) begin
            timed_out = 1'b1;
            timeout_errors++;
            $display("%0t: timed out waiting for %s", $time, what);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatch, %0d timeout, %0d other, %0d results checked",
                 mismatch_errors, timeout_errors, other_errors, rx_count);
        if (mismatch_errors + timeout_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Result monitor and output credits.
    // ~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        mem_pkg::mem_wb_t exp;
        bit               full;
        if (rst_n) begin
            if (in_credit) begin
                credits_back++;
            end
            if (credits_back > sent) begin
                other_errors++;
                $display("%0t: more input credits returned than operations sent", $time);
            end
            if (out_valid && exp_q.size() == 0) begin
                other_errors++;
                $display("%0t: result arrived with no operation outstanding", $time);
            end else if (out_valid) begin
                exp  = exp_q.pop_front();
                full = full_q.pop_front();
                if (out_res.write_en !== exp.write_en || (full &&
                    (out_res.write_addr !== exp.write_addr ||
                     out_res.write_data !== exp.write_data))) begin
                    mismatch_errors++;
                    $display("mismatch at %0t: result %0d en=%0b rd=%0d data=%h, expected %0b %0d %h",
                             $time, rx_count, out_res.write_en, out_res.write_addr,
                             out_res.write_data, exp.write_en, exp.write_addr, exp.write_data);
                end
            end
            if (out_valid) begin
                rx_count++;
            end
            if (rx_count - returned > mem_pkg::OUT_CREDITS) begin
                other_errors++;
                $display("%0t: more results outstanding than output credits", $time);
            end
        end
    end

    always @(posedge clk) begin
        bit take;
        #0.5;
        out_credit = 1'b0;
        if (rst_n && rx_count > returned) begin
            take = lfsr[0];
            lfsr = lfsr_next(lfsr);   // One step per bit taken.
            if (take) begin
                out_credit = 1'b1;
                returned++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        int               fd;
        string            line;
        mem_pkg::ex_mem_t op;
        mem_pkg::bus64_t  line_cnt;
        mem_pkg::mem_wb_t exp;
        bit               full;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_op      = '0;
        cnt        = '0;
        out_credit = 1'b0;
        lfsr       = 16'd35;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        foreach (ref_csr[i]) ref_csr[i] = '0;
        fd = $fopen(STIM_FILE, "r");
        repeat (16) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        if (fd == 0) begin
            other_errors++;
            $display("could not open the stimulus file %s", STIM_FILE);
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if (!parse_line(line, op, line_cnt)) begin
                    continue;
                end
                wait_for(WAIT_IN_CREDIT, "an input credit");
                // Counter value stays put while a result may still read it.
                if (line_cnt !== cnt) begin
                    wait_for(WAIT_DRAIN, "outstanding results before a counter change");
                end
                if (timed_out) begin
                    break;
                end
                model_op(op, line_cnt, exp, full);
                exp_q.push_back(exp);
                full_q.push_back(full);
                in_valid = 1'b1;
                in_op    = op;
                cnt      = line_cnt;
                sent++;
                next_drive_slot();
                in_valid = 1'b0;
            end
            $fclose(fd);
        end
        wait_for(WAIT_DRAIN, "the remaining results");
        wait_for(WAIT_OUT_RETURN, "output credits to be returned");
        wait_for(WAIT_IN_RETURN, "every input credit to come back");
        if (sent == 0) begin
            other_errors++;
            $display("no operations were read from the stimulus file");
        end
        finish_run();
    end

endmodule

// ==== mem_stage_top.f ====
rtl/mem_pkg.sv
rtl/mem_issue_queue.sv
rtl/mem_access.sv
rtl/data_ram.sv
rtl/csr_file.sv
rtl/mem_writeback.sv
rtl/mem_stage_top.sv
testbench/mem_stage_chk.sv
testbench/mem_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage_top.f
FLAGS     ?= --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/mem_stim.txt ====
# op en rd reg_write_data mem_addr csr_addr csr_write_data csr_mask cnt, all hex
# op codes follow mem_op_t order, 0 is OP_ALU up to d for OP_RDCNTVHW
7 0 00 8091a2f3 10 0000 00000000 00000000 0
1 1 01 00000000 10 0000 00000000 00000000 0
1 1 02 00000000 11 0000 00000000 00000000 0
1 1 03 00000000 13 0000 00000000 00000000 0
2 1 04 00000000 10 0000 00000000 00000000 0
2 1 05 00000000 12 0000 00000000 00000000 0
3 1 06 00000000 10 0000 00000000 00000000 0
3 1 07 00000000 12 0000 00000000 00000000 0
4 1 08 00000000 12 0000 00000000 00000000 0
4 1 09 00000000 11 0000 00000000 00000000 0
3 1 0a 00000000 13 0000 00000000 00000000 0
5 1 0b 00000000 10 0000 00000000 00000000 0
6 0 00 0000007f 14 0000 00000000 00000000 0
6 0 00 000000c5 17 0000 00000000 00000000 0
5 1 0c 00000000 14 0000 00000000 00000000 0
1 1 0d 00000000 17 0000 00000000 00000000 0
9 1 0e 00000000 00 0003 12345678 00000000 0
8 1 0f 00000000 00 0003 00000000 00000000 0
0 1 10 00000042 00 0000 00000000 00000000 0
8 1 11 00000000 00 0003 00000000 00000000 0
a 1 12 00000000 00 0003 ffffffff 0000ff00 0
8 1 13 00000000 00 0003 00000000 00000000 0
b 1 14 00000000 00 0000 00000000 00000000 0
9 1 15 00000000 00 0040 deadbeef 00000000 0
8 1 16 00000000 00 0040 00000000 00000000 0
c 1 17 00000000 00 0000 00000000 00000000 0123456789abcdef
d 1 18 00000000 00 0000 00000000 00000000 0123456789abcdef
0 0 19 cafef00d 00 0000 00000000 00000000 0
0 1 1f ffffffff 00 0000 00000000 00000000 0
